// File: source/soc_settings.svh
// Sizes in bytes unless noted; AHB data is fixed at 64 bits and every base is window aligned
`ifndef SOC_SETTINGS_SVH
`define SOC_SETTINGS_SVH

// ----------------------------------------
// Bus widths
// ----------------------------------------
`define AHB_ADDR_WIDTH       32
`define AHB_DATA_WIDTH       64
`define APB_ADDR_WIDTH       32
`define APB_DATA_WIDTH       32

// ----------------------------------------
// Core-side address map
// ----------------------------------------
`define LMEM_BASE_ADDR       32'h0000_0000
`define LMEM_DEPTH           512
`define MBOX_BASE_ADDR       32'h3000_0000
`define MBOX_WINDOW          32'h0000_1000

// Mailbox layout with buffer depth in 32-bit words
`define MBOX_DEPTH           16
`define MBOX_DATA_OFFSET     32'h0000_0100
`define APB_FUSE_DONE_OFFSET 32'h0000_0000
`define APB_DOORBELL_OFFSET  32'h0000_0004
`define APB_STATUS_OFFSET    32'h0000_0008

// Clock edges from fuse-done to core reset release
`define UC_RST_DELAY         4

`endif

// File: source/soc_pkg.sv
// Bus vector widths follow soc_settings.svh; only the four basic AHB transfer types are modeled
`include "soc_settings.svh"

package soc_pkg;

    // ----------------------------------------
    // Bus vectors
    // ----------------------------------------
    typedef logic [`AHB_ADDR_WIDTH-1:0] ahb_addr_t;
    typedef logic [`AHB_DATA_WIDTH-1:0] ahb_data_t;
    typedef logic [`APB_ADDR_WIDTH-1:0] apb_addr_t;
    typedef logic [`APB_DATA_WIDTH-1:0] apb_data_t;

    // AHB HTRANS encoding
    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        BUSY   = 2'b01,
        NONSEQ = 2'b10,
        SEQ    = 2'b11
    } htrans_e;

    // Core reset release sequence
    typedef enum logic [1:0] {
        BOOT_WAIT_FUSE,
        BOOT_RELEASE,
        BOOT_DONE
    } boot_state_e;

    // Slave picked by the address decoder
    typedef enum logic [1:0] {
        SLV_LMEM,
        SLV_MBOX,
        SLV_NONE
    } ahb_slave_e;

endpackage

// File: source/ahb_node.sv
// Single master, two slaves; slave selects are masked while a wait state holds the master
`timescale 1ns/1ps
`include "soc_settings.svh"

module ahb_node (
    input  logic               core_clk_i,
    input  logic               arst_n_i,
    input  soc_pkg::ahb_addr_t haddr_i,
    input  soc_pkg::htrans_e   htrans_i,
    output logic               lmem_hsel_o,
    output logic               mbox_hsel_o,
    input  soc_pkg::ahb_data_t lmem_hrdata_i,
    input  soc_pkg::ahb_data_t mbox_hrdata_i,
    input  logic               lmem_hreadyout_i,
    input  logic               mbox_hreadyout_i,
    input  logic               lmem_hresp_i,
    input  logic               mbox_hresp_i,
    output soc_pkg::ahb_data_t hrdata_o,
    output logic               hready_o,
    output logic               hresp_o
);
    import soc_pkg::*;

    localparam ahb_addr_t LMEM_BYTES = ahb_addr_t'(`LMEM_DEPTH * (`AHB_DATA_WIDTH / 8));
    localparam ahb_addr_t MBOX_BYTES = ahb_addr_t'(`MBOX_WINDOW);

    ahb_slave_e addr_sel;
    ahb_slave_e dsel_q;
    logic       trans_vld;
    logic       err_first_q;
    logic       err_second_q;

    // ----------------------------------------
    // Address phase decode
    // ----------------------------------------
    assign trans_vld = (htrans_i == NONSEQ) || (htrans_i == SEQ);

    // Unsigned wrap makes one compare cover both window bounds
    always_comb
    begin
        if ((haddr_i - `LMEM_BASE_ADDR) < LMEM_BYTES)
            addr_sel = SLV_LMEM;
        else if ((haddr_i - `MBOX_BASE_ADDR) < MBOX_BYTES)
            addr_sel = SLV_MBOX;
        else
            addr_sel = SLV_NONE;
    end

    assign lmem_hsel_o = hready_o && (addr_sel == SLV_LMEM);
    assign mbox_hsel_o = hready_o && (addr_sel == SLV_MBOX);

    // ----------------------------------------
    // Data phase tracking
    // ----------------------------------------
    always_ff @(posedge core_clk_i or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            dsel_q       <= SLV_NONE;
            err_first_q  <= 1'b0;
            err_second_q <= 1'b0;
        end
        else
        begin
            // Second error cycle always follows the first
            err_second_q <= err_first_q;
            err_first_q  <= hready_o && trans_vld && (addr_sel == SLV_NONE);
            if (hready_o)
                dsel_q <= trans_vld ? addr_sel : SLV_NONE;
        end
    end

    // Response steering back to the master
    always_comb
    begin
        case (dsel_q)
            SLV_LMEM:
            begin
                hrdata_o = lmem_hrdata_i;
                hready_o = lmem_hreadyout_i;
                hresp_o  = lmem_hresp_i;
            end
            SLV_MBOX:
            begin
                hrdata_o = mbox_hrdata_i;
                hready_o = mbox_hreadyout_i;
                hresp_o  = mbox_hresp_i;
            end
            default:
            begin
                // Idle data phase or the built-in error slave
                hrdata_o = '0;
                hready_o = !err_first_q;
                hresp_o  = err_first_q || err_second_q;
            end
        endcase
    end

endmodule

// File: source/ahb_sram.sv
// Zero-wait 64-bit word memory, full-width accesses only; contents are not cleared by reset
`timescale 1ns/1ps
`include "soc_settings.svh"

module ahb_sram (
    input  logic               core_clk_i,
    input  logic               rst_n_i,
    input  logic               hsel_i,
    input  soc_pkg::ahb_addr_t haddr_i,
    input  soc_pkg::htrans_e   htrans_i,
    input  logic               hwrite_i,
    input  soc_pkg::ahb_data_t hwdata_i,
    output soc_pkg::ahb_data_t hrdata_o,
    output logic               hreadyout_o,
    output logic               hresp_o
);
    import soc_pkg::*;

    localparam int IDX_W = $clog2(`LMEM_DEPTH);
    localparam int LSB   = $clog2(`AHB_DATA_WIDTH / 8);

    ahb_data_t        mem [`LMEM_DEPTH];
    logic             aphase;
    logic             dvld_q;
    logic             dwrite_q;
    logic [IDX_W-1:0] didx_q;

    assign aphase = hsel_i && ((htrans_i == NONSEQ) || (htrans_i == SEQ));

    // ----------------------------------------
    // Address phase capture
    // ----------------------------------------
    always_ff @(posedge core_clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            dvld_q   <= 1'b0;
            dwrite_q <= 1'b0;
            didx_q   <= '0;
        end
        else
        begin
            dvld_q   <= aphase;
            dwrite_q <= hwrite_i;
            didx_q   <= haddr_i[LSB +: IDX_W];
        end
    end

    // ----------------------------------------
    // Data phase
    // ----------------------------------------
    always_ff @(posedge core_clk_i)
    begin
        if (dvld_q && dwrite_q)
            mem[didx_q] <= hwdata_i;
    end

    // Async read so a read right behind a write sees the new word
    assign hrdata_o = (dvld_q && !dwrite_q) ? mem[didx_q] : '0;

    // Never stalls, never errors
    assign hreadyout_o = 1'b1;
    assign hresp_o     = 1'b0;

endmodule

// File: source/mbox_boot_fsm.sv
// Core reset is released exactly UC_RST_DELAY edges after fuse-done and held until the next arst
`timescale 1ns/1ps
`include "soc_settings.svh"

module mbox_boot_fsm (
    input  logic core_clk_i,
    input  logic arst_n_i,
    input  logic fuse_done_i,
    output logic uc_rst_n_o
);
    import soc_pkg::*;

    localparam int               CNT_W    = $clog2(`UC_RST_DELAY + 1);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`UC_RST_DELAY - 1);

    boot_state_e      state_q;
    logic [CNT_W-1:0] cnt_q;

    // Reset output comes straight from a flop
    always_ff @(posedge core_clk_i or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            state_q    <= BOOT_WAIT_FUSE;
            cnt_q      <= '0;
            uc_rst_n_o <= 1'b0;
        end
        else
        begin
            case (state_q)
                BOOT_WAIT_FUSE:
                begin
                    cnt_q <= '0;
                    if (fuse_done_i)
                        state_q <= BOOT_RELEASE;
                end
                BOOT_RELEASE:
                begin
                    if (cnt_q == CNT_LAST)
                    begin
                        state_q    <= BOOT_DONE;
                        uc_rst_n_o <= 1'b1;
                    end
                    else
                        cnt_q <= cnt_q + 1'b1;
                end
                // Further fuse-done pulses are ignored here
                BOOT_DONE:
                    uc_rst_n_o <= 1'b1;
                default:
                    state_q <= BOOT_WAIT_FUSE;
            endcase
        end
    end

endmodule

// File: source/mbox_csr.sv
// Zero-wait APB and AHB sides; the AHB offset is taken from low address bits so the base must be aligned
`timescale 1ns/1ps
`include "soc_settings.svh"

module mbox_csr (
    input  logic               core_clk_i,
    input  logic               arst_n_i,
    input  logic               uc_rst_n_i,
    // APB from the SoC
    input  soc_pkg::apb_addr_t paddr_i,
    input  logic               psel_i,
    input  logic               penable_i,
    input  logic               pwrite_i,
    input  soc_pkg::apb_data_t pwdata_i,
    output logic               pready_o,
    output soc_pkg::apb_data_t prdata_o,
    output logic               pslverr_o,
    // AHB from the core
    input  logic               hsel_i,
    input  soc_pkg::ahb_addr_t haddr_i,
    input  soc_pkg::htrans_e   htrans_i,
    input  logic               hwrite_i,
    input  soc_pkg::ahb_data_t hwdata_i,
    output soc_pkg::ahb_data_t hrdata_o,
    output logic               hreadyout_o,
    output logic               hresp_o,
    // To the boot sequencer
    output logic               fuse_done_o
);
    import soc_pkg::*;

    localparam int               IDX_W     = $clog2(`MBOX_DEPTH);
    localparam int               OFF_W     = $clog2(`MBOX_WINDOW);
    localparam apb_addr_t        APB_BUF_B = apb_addr_t'(`MBOX_DEPTH * 4);
    localparam logic [OFF_W-1:0] AHB_BUF_B = OFF_W'(`MBOX_DEPTH * 4);
    localparam logic [OFF_W-1:0] AHB_BUF_0 = OFF_W'(`MBOX_DATA_OFFSET);

    apb_data_t        mbox_buf [`MBOX_DEPTH];
    logic             doorbell_q;

    apb_addr_t        apb_off;
    logic [IDX_W-1:0] apb_idx;
    logic             apb_buf_hit;
    logic             apb_hit;
    logic             apb_wr;
    logic             apb_db_set;

    logic             aphase;
    logic             dvld_q;
    logic             dwrite_q;
    logic [OFF_W-1:0] doff_q;
    logic [OFF_W-1:0] ahb_off;
    logic [IDX_W-2:0] ahb_pair;
    logic             ahb_buf_hit;
    logic             ahb_db_hit;
    logic             ahb_db_clr;
    logic             ahb_buf_wr;

    // ----------------------------------------
    // APB side
    // ----------------------------------------
    assign apb_off     = paddr_i - `MBOX_DATA_OFFSET;
    assign apb_idx     = apb_off[2 +: IDX_W];
    assign apb_buf_hit = (apb_off < APB_BUF_B) && (paddr_i[1:0] == 2'b00);

    always_comb
    begin
        prdata_o = '0;
        apb_hit  = 1'b1;
        if (apb_buf_hit)
            prdata_o = mbox_buf[apb_idx];
        else if (paddr_i == `APB_STATUS_OFFSET)
            prdata_o = {{(`APB_DATA_WIDTH-2){1'b0}}, doorbell_q, uc_rst_n_i};
        else if (paddr_i == `APB_DOORBELL_OFFSET)
            prdata_o = {{(`APB_DATA_WIDTH-1){1'b0}}, doorbell_q};
        else if (paddr_i != `APB_FUSE_DONE_OFFSET)
            apb_hit = 1'b0;
    end

    assign pready_o    = 1'b1;
    assign pslverr_o   = psel_i && penable_i && !apb_hit;
    assign apb_wr      = psel_i && penable_i && pwrite_i && apb_hit;
    assign apb_db_set  = apb_wr && (paddr_i == `APB_DOORBELL_OFFSET);
    // Seen by the boot FSM at the edge closing the access phase
    assign fuse_done_o = apb_wr && (paddr_i == `APB_FUSE_DONE_OFFSET) && pwdata_i[0];

    // ----------------------------------------
    // AHB side
    // ----------------------------------------
    assign aphase = hsel_i && ((htrans_i == NONSEQ) || (htrans_i == SEQ));

    always_ff @(posedge core_clk_i or negedge uc_rst_n_i)
    begin
        if (!uc_rst_n_i)
        begin
            dvld_q   <= 1'b0;
            dwrite_q <= 1'b0;
            doff_q   <= '0;
        end
        else
        begin
            dvld_q   <= aphase;
            dwrite_q <= hwrite_i;
            doff_q   <= haddr_i[OFF_W-1:0];
        end
    end

    assign ahb_off     = doff_q - AHB_BUF_0;
    assign ahb_pair    = ahb_off[3 +: IDX_W-1];
    assign ahb_buf_hit = (ahb_off < AHB_BUF_B) && (doff_q[2:0] == 3'b000);
    assign ahb_db_hit  = (doff_q == '0);
    assign ahb_db_clr  = dvld_q && dwrite_q && ahb_db_hit;
    assign ahb_buf_wr  = dvld_q && dwrite_q && ahb_buf_hit;

    // Lower buffer word in bits 31:0
    always_comb
    begin
        hrdata_o = '0;
        if (dvld_q && !dwrite_q)
        begin
            if (ahb_db_hit)
                hrdata_o = {{(`AHB_DATA_WIDTH-1){1'b0}}, doorbell_q};
            else if (ahb_buf_hit)
                hrdata_o = {mbox_buf[{ahb_pair, 1'b1}], mbox_buf[{ahb_pair, 1'b0}]};
        end
    end

    assign hreadyout_o = 1'b1;
    assign hresp_o     = 1'b0;

    // ----------------------------------------
    // Storage
    // ----------------------------------------
    // Core clear wins over a same-cycle SoC set
    always_ff @(posedge core_clk_i or negedge arst_n_i)
    begin
        if (!arst_n_i)
            doorbell_q <= 1'b0;
        else if (ahb_db_clr)
            doorbell_q <= 1'b0;
        else if (apb_db_set)
            doorbell_q <= 1'b1;
    end

    // Core may post a reply pair; it lands after the SoC write
    always_ff @(posedge core_clk_i)
    begin
        if (apb_wr && apb_buf_hit)
            mbox_buf[apb_idx] <= pwdata_i;
        if (ahb_buf_wr)
        begin
            mbox_buf[{ahb_pair, 1'b0}] <= hwdata_i[31:0];
            mbox_buf[{ahb_pair, 1'b1}] <= hwdata_i[63:32];
        end
    end

endmodule

// File: source/uc_subsys_top.sv
// Core bus is an external AHB-lite master port doing single 64-bit transfers; slaves sit in core reset
`timescale 1ns/1ps

module uc_subsys_top (
    input  logic               core_clk_i,
    input  logic               arst_n_i,
    // APB from the SoC
    input  logic               psel_i,
    input  logic               penable_i,
    input  logic               pwrite_i,
    input  soc_pkg::apb_addr_t paddr_i,
    input  soc_pkg::apb_data_t pwdata_i,
    output logic               pready_o,
    output soc_pkg::apb_data_t prdata_o,
    output logic               pslverr_o,
    // AHB master port in place of the core
    input  soc_pkg::ahb_addr_t haddr_i,
    input  soc_pkg::htrans_e   htrans_i,
    input  logic               hwrite_i,
    input  soc_pkg::ahb_data_t hwdata_i,
    output soc_pkg::ahb_data_t hrdata_o,
    output logic               hready_o,
    output logic               hresp_o,
    // Core reset from the boot sequencer
    output logic               uc_rst_n_o
);
    import soc_pkg::*;

    logic      fuse_done;
    logic      lmem_hsel;
    logic      mbox_hsel;
    ahb_data_t lmem_hrdata;
    ahb_data_t mbox_hrdata;
    logic      lmem_hreadyout;
    logic      mbox_hreadyout;
    logic      lmem_hresp;
    logic      mbox_hresp;

    // ----------------------------------------
    // Decoder and default slave
    // ----------------------------------------
    ahb_node u_ahb_node (
        .core_clk_i       (core_clk_i),
        .arst_n_i         (arst_n_i),
        .haddr_i          (haddr_i),
        .htrans_i         (htrans_i),
        .lmem_hsel_o      (lmem_hsel),
        .mbox_hsel_o      (mbox_hsel),
        .lmem_hrdata_i    (lmem_hrdata),
        .mbox_hrdata_i    (mbox_hrdata),
        .lmem_hreadyout_i (lmem_hreadyout),
        .mbox_hreadyout_i (mbox_hreadyout),
        .lmem_hresp_i     (lmem_hresp),
        .mbox_hresp_i     (mbox_hresp),
        .hrdata_o         (hrdata_o),
        .hready_o         (hready_o),
        .hresp_o          (hresp_o)
    );

    // Local memory
    ahb_sram u_ahb_sram (
        .core_clk_i  (core_clk_i),
        .rst_n_i     (uc_rst_n_o),
        .hsel_i      (lmem_hsel),
        .haddr_i     (haddr_i),
        .htrans_i    (htrans_i),
        .hwrite_i    (hwrite_i),
        .hwdata_i    (hwdata_i),
        .hrdata_o    (lmem_hrdata),
        .hreadyout_o (lmem_hreadyout),
        .hresp_o     (lmem_hresp)
    );

    // ----------------------------------------
    // Mailbox and boot control
    // ----------------------------------------
    mbox_csr u_mbox_csr (
        .core_clk_i  (core_clk_i),
        .arst_n_i    (arst_n_i),
        .uc_rst_n_i  (uc_rst_n_o),
        .paddr_i     (paddr_i),
        .psel_i      (psel_i),
        .penable_i   (penable_i),
        .pwrite_i    (pwrite_i),
        .pwdata_i    (pwdata_i),
        .pready_o    (pready_o),
        .prdata_o    (prdata_o),
        .pslverr_o   (pslverr_o),
        .hsel_i      (mbox_hsel),
        .haddr_i     (haddr_i),
        .htrans_i    (htrans_i),
        .hwrite_i    (hwrite_i),
        .hwdata_i    (hwdata_i),
        .hrdata_o    (mbox_hrdata),
        .hreadyout_o (mbox_hreadyout),
        .hresp_o     (mbox_hresp),
        .fuse_done_o (fuse_done)
    );

    mbox_boot_fsm u_mbox_boot_fsm (
        .core_clk_i  (core_clk_i),
        .arst_n_i    (arst_n_i),
        .fuse_done_i (fuse_done),
        .uc_rst_n_o  (uc_rst_n_o)
    );

endmodule

// File: sim/tb_uc_subsys.sv
// One AHB master and one APB master drive the subsystem; AHB accesses are single 64-bit transfers
`timescale 1ns/1ps
`include "soc_settings.svh"

module tb_uc_subsys;
    import soc_pkg::*;

    localparam int TIMEOUT  = 50;
    localparam int PIPE_MAX = 8;

    logic      clk;
    logic      arst_n;
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    apb_data_t pwdata;
    logic      pready;
    apb_data_t prdata;
    logic      pslverr;
    ahb_addr_t haddr;
    htrans_e   htrans;
    logic      hwrite;
    ahb_data_t hwdata;
    ahb_data_t hrdata;
    logic      hready;
    logic      hresp;
    logic      uc_rst_n;

    // Pipeline slots hold write data or the expected read data
    logic      pipe_wr   [PIPE_MAX];
    ahb_addr_t pipe_addr [PIPE_MAX];
    ahb_data_t pipe_data [PIPE_MAX];

    // Reference contents
    ahb_data_t lmem_model [`LMEM_DEPTH];
    apb_data_t mbox_model [`MBOX_DEPTH];

    uc_subsys_top u_uc_subsys_top (
        .core_clk_i (clk),
        .arst_n_i   (arst_n),
        .psel_i     (psel),
        .penable_i  (penable),
        .pwrite_i   (pwrite),
        .paddr_i    (paddr),
        .pwdata_i   (pwdata),
        .pready_o   (pready),
        .prdata_o   (prdata),
        .pslverr_o  (pslverr),
        .haddr_i    (haddr),
        .htrans_i   (htrans),
        .hwrite_i   (hwrite),
        .hwdata_i   (hwdata),
        .hrdata_o   (hrdata),
        .hready_o   (hready),
        .hresp_o    (hresp),
        .uc_rst_n_o (uc_rst_n)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ----------------------------------------
    // Failure reporting and checks
    // ----------------------------------------
    task automatic report_failure(input string what);
        $display("[ERROR] %0t ns %s", $time, what);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic report_mismatch(input string sig, input logic [63:0] got,
                                   input logic [63:0] exp);
        $display("[ERROR] %0t ns %s = 0x%0h, expected 0x%0h", $time, sig, got, exp);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_eq(input string sig, input logic [63:0] got, input logic [63:0] exp);
        assert (got === exp)
        else
            report_mismatch(sig, got, exp);
    endtask

    // APB side has no wait states
    pready_high: assert property (@(posedge clk) disable iff (!arst_n) pready)
    else
        report_failure("pready_o went low outside reset");

    function automatic ahb_data_t random_word64();
        return {$urandom(), $urandom()};
    endfunction

    // ----------------------------------------
    // APB master
    // ----------------------------------------
    task automatic apb_access(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
                              output apb_data_t rdata, output logic err);
        int cycles;
        cycles = 0;
        @(posedge clk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clk);
        #1;
        penable = 1'b1;
        @(negedge clk);
        while (!pready)
        begin
            cycles++;
            if (cycles > TIMEOUT)
                report_failure("APB access phase never completed");
            @(negedge clk);
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input apb_addr_t addr, input apb_data_t wdata, input logic exp_err);
        apb_data_t rd;
        logic      err;
        apb_access(1'b1, addr, wdata, rd, err);
        check_eq("pslverr_o", 64'(err), 64'(exp_err));
    endtask

    task automatic apb_read_check(input apb_addr_t addr, input apb_data_t exp);
        apb_data_t rd;
        logic      err;
        apb_access(1'b0, addr, '0, rd, err);
        check_eq("pslverr_o", 64'(err), 64'h0);
        check_eq("prdata_o", 64'(rd), 64'(exp));
    endtask

    // ----------------------------------------
    // AHB master
    // ----------------------------------------
    task automatic wait_hready();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!hready)
        begin
            cycles++;
            if (cycles > TIMEOUT)
                report_failure("hready_o stayed low too long");
            @(negedge clk);
        end
    endtask

    task automatic pipe_set(input int i, input logic wr, input ahb_addr_t addr,
                            input ahb_data_t data);
        pipe_wr[i]   = wr;
        pipe_addr[i] = addr;
        pipe_data[i] = data;
    endtask

    // Address phase of slot i overlaps the data phase of slot i-1
    task automatic ahb_pipe(input int n);
        @(posedge clk);
        #1;
        for (int i = 0; i <= n; i++)
        begin
            if (i < n)
            begin
                haddr  = pipe_addr[i];
                htrans = NONSEQ;
                hwrite = pipe_wr[i];
            end
            else
            begin
                htrans = IDLE;
                hwrite = 1'b0;
            end
            if (i > 0)
            begin
                if (pipe_wr[i-1])
                    hwdata = pipe_data[i-1];
            end
            wait_hready();
            if (i > 0)
            begin
                check_eq("hresp_o", 64'(hresp), 64'h0);
                if (!pipe_wr[i-1])
                    check_eq("hrdata_o", hrdata, pipe_data[i-1]);
            end
            @(posedge clk);
            #1;
        end
    endtask

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    initial
    begin
        int idx;
        int lmem_idx;
        void'($urandom(76));
        arst_n  = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        haddr   = '0;
        htrans  = IDLE;
        hwrite  = 1'b0;
        hwdata  = '0;
        repeat (8) @(posedge clk);
        #1;
        arst_n = 1'b1;

        @(negedge clk);
        check_eq("hready_o", 64'(hready), 64'h1);
        check_eq("hresp_o", 64'(hresp), 64'h0);
        check_eq("pslverr_o", 64'(pslverr), 64'h0);
        check_eq("uc_rst_n_o", 64'(uc_rst_n), 64'h0);
        apb_read_check(`APB_STATUS_OFFSET, 32'h0);

        // Memory still answers with zero while the core is in reset
        pipe_set(0, 1'b0, `LMEM_BASE_ADDR, '0);
        ahb_pipe(1);

        // Boot release
        for (int i = 0; i < 20; i++)
        begin
            @(negedge clk);
            check_eq("uc_rst_n_o", 64'(uc_rst_n), 64'h0);
        end
        apb_write(`APB_FUSE_DONE_OFFSET, 32'h1, 1'b0);
        for (int i = 0; i < `UC_RST_DELAY; i++)
        begin
            @(negedge clk);
            check_eq("uc_rst_n_o", 64'(uc_rst_n), 64'h0);
        end
        @(negedge clk);
        check_eq("uc_rst_n_o", 64'(uc_rst_n), 64'h1);
        apb_read_check(`APB_STATUS_OFFSET, 32'h1);

        // Local memory pipelined writes then reads
        for (int i = 0; i < PIPE_MAX; i++)
        begin
            idx = int'($urandom % `LMEM_DEPTH);
            lmem_model[idx] = random_word64();
            pipe_set(i, 1'b1, ahb_addr_t'(`LMEM_BASE_ADDR + idx * 8), lmem_model[idx]);
        end
        ahb_pipe(PIPE_MAX);
        for (int i = 0; i < PIPE_MAX; i++)
        begin
            idx = int'((pipe_addr[i] - `LMEM_BASE_ADDR) >> 3);
            pipe_set(i, 1'b0, pipe_addr[i], lmem_model[idx]);
        end
        ahb_pipe(PIPE_MAX);

        // Read right behind a write to the same word
        idx = int'($urandom % `LMEM_DEPTH);
        lmem_model[idx] = random_word64();
        pipe_set(0, 1'b1, ahb_addr_t'(`LMEM_BASE_ADDR + idx * 8), lmem_model[idx]);
        pipe_set(1, 1'b0, ahb_addr_t'(`LMEM_BASE_ADDR + idx * 8), lmem_model[idx]);
        ahb_pipe(2);
        lmem_idx = idx;

        // SoC writes the mailbox buffer and the core reads word pairs
        for (int i = 0; i < `MBOX_DEPTH; i++)
        begin
            mbox_model[i] = $urandom();
            apb_write(apb_addr_t'(`MBOX_DATA_OFFSET + 4 * i), mbox_model[i], 1'b0);
        end
        for (int p = 0; p < `MBOX_DEPTH / 2; p++)
        begin
            pipe_set(p, 1'b0, ahb_addr_t'(`MBOX_BASE_ADDR + `MBOX_DATA_OFFSET + 8 * p),
                     {mbox_model[2 * p + 1], mbox_model[2 * p]});
        end
        ahb_pipe(`MBOX_DEPTH / 2);
        for (int i = 0; i < 4; i++)
        begin
            idx = int'($urandom % `MBOX_DEPTH);
            apb_read_check(apb_addr_t'(`MBOX_DATA_OFFSET + 4 * idx), mbox_model[idx]);
        end

        // Doorbell set by the SoC and cleared by the core
        apb_write(`APB_DOORBELL_OFFSET, 32'h1, 1'b0);
        apb_read_check(`APB_STATUS_OFFSET, 32'h3);
        pipe_set(0, 1'b0, `MBOX_BASE_ADDR, 64'h1);
        ahb_pipe(1);
        pipe_set(0, 1'b1, `MBOX_BASE_ADDR, 64'h0);
        pipe_set(1, 1'b0, `MBOX_BASE_ADDR, 64'h0);
        ahb_pipe(2);
        apb_read_check(`APB_STATUS_OFFSET, 32'h1);

        // Unmapped core address gets the two-cycle error
        @(posedge clk);
        #1;
        haddr  = 32'h8000_0000;
        htrans = NONSEQ;
        hwrite = 1'b0;
        wait_hready();
        @(posedge clk);
        #1;
        htrans = IDLE;
        @(negedge clk);
        check_eq("hresp_o", 64'(hresp), 64'h1);
        check_eq("hready_o", 64'(hready), 64'h0);
        @(negedge clk);
        check_eq("hresp_o", 64'(hresp), 64'h1);
        check_eq("hready_o", 64'(hready), 64'h1);

        // Unmapped APB offsets change nothing
        apb_write(32'h0000_0050, $urandom(), 1'b1);
        apb_write(apb_addr_t'(`MBOX_DATA_OFFSET + 4 * `MBOX_DEPTH), $urandom(), 1'b1);
        apb_read_check(`APB_STATUS_OFFSET, 32'h1);
        for (int i = 0; i < `MBOX_DEPTH; i++)
        begin
            apb_read_check(apb_addr_t'(`MBOX_DATA_OFFSET + 4 * i), mbox_model[i]);
        end

        // A new reset clears the doorbell and holds the core again
        apb_write(`APB_DOORBELL_OFFSET, 32'h1, 1'b0);
        @(posedge clk);
        #1;
        arst_n = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        arst_n = 1'b1;
        @(negedge clk);
        check_eq("uc_rst_n_o", 64'(uc_rst_n), 64'h0);
        apb_read_check(`APB_STATUS_OFFSET, 32'h0);

        // Stored words read as zero while the core is held
        pipe_set(0, 1'b0, ahb_addr_t'(`LMEM_BASE_ADDR + lmem_idx * 8), '0);
        pipe_set(1, 1'b0, ahb_addr_t'(`MBOX_BASE_ADDR + `MBOX_DATA_OFFSET), '0);
        ahb_pipe(2);

        $display("TESTS PASSED");
        $finish;
    end

endmodule

// File: tb.f
+incdir+source
source/soc_pkg.sv
source/ahb_node.sv
source/ahb_sram.sv
source/mbox_boot_fsm.sv
source/mbox_csr.sv
source/uc_subsys_top.sv
sim/tb_uc_subsys.sv

// File: run_verilator.sh
#!/bin/sh
# Build the testbench with Verilator and run it; a failing check ends the run with $fatal
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f tb.f --top-module tb_uc_subsys -o sim_uc_subsys &&
./obj_dir/sim_uc_subsys ||
exit 1
